// File: Makefile
SIM      := verilator
TOP      := tempSensorReader_tb
FILELIST := tempSensorReader.f
FLAGS    := --binary --timing --assert --top-module $(TOP)
BUILD    := obj_dir
PASS_MSG := Test OK

BIN     := $(BUILD)/V$(TOP)
SOURCES := $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SOURCES) $(FILELIST)
	$(SIM) $(FLAGS) --Mdir $(BUILD) -f $(FILELIST)

run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(BUILD)

// File: rtl/bitTimer.sv
module bitTimer import i2cPkg::*; #(
    parameter logic [15:0] ClkPerPhase = 16'd1
) (
    input  logic    FSM_Clk,
    input  logic    rstN,
    output logic    scl,
    i2cBitIf.timer  bus
);

    logic busy;
    stepE stepQ;
    stepE curStep;
    logic [15:0] cycCnt;
    phaseT phaseQ;
    logic [BitIdxW-1:0] bitQ;
    logic active;
    logic lastCyc;
    logic lastPhase;
    logic lastBit;

    // The cycle carrying stepGo already counts as the first cycle of the step
    assign active = busy | bus.stepGo;
    assign curStep = busy ? stepQ : bus.step;

    assign lastCyc = (cycCnt == ClkPerPhase - 16'd1);
    assign lastPhase = (phaseQ == phaseT'(PhasesPerBit - 1));

    // Byte slots run nine bits, conditions one
    assign lastBit = (curStep == stepWrite || curStep == stepRead)
        ? (bitQ == BitIdxW'(BitsPerByteSlot - 1))
        : (bitQ == '0);

    assign bus.stepDone = active && lastCyc && lastPhase && lastBit;
    assign bus.phase = phaseQ;
    assign bus.bitIdx = bitQ;

    always_comb begin
        if (!active) begin
            scl = 1'b1;
        end else if (curStep == stepStop) begin
            // Stop leaves SCL high from phase one onward
            scl = (phaseQ != PhaseSetup);
        end else begin
            scl = (phaseQ == PhaseRise) || (phaseQ == PhaseSample);
        end
    end

    always_ff @(posedge FSM_Clk or negedge rstN) begin
        if (!rstN) begin
            busy <= 1'b0;
            stepQ <= stepStart;
            cycCnt <= '0;
            phaseQ <= PhaseSetup;
            bitQ <= '0;
        end else if (active) begin
            if (bus.stepGo) begin
                stepQ <= bus.step;
            end
            if (bus.stepDone) begin
                busy <= 1'b0;
                cycCnt <= '0;
                phaseQ <= PhaseSetup;
                bitQ <= '0;
            end else begin
                busy <= 1'b1;
                if (lastCyc) begin
                    cycCnt <= '0;
                    phaseQ <= phaseQ + 2'd1;
                    if (lastPhase) begin
                        bitQ <= bitQ + BitIdxW'(1);
                    end
                end else begin
                    cycCnt <= cycCnt + 16'd1;
                end
            end
        end
    end

endmodule

// File: rtl/byteShifter.sv
module byteShifter import i2cPkg::*; (
    input  logic      FSM_Clk,
    input  logic      rstN,
    input  logic      sdaIn,
    output logic      sdaPullLow,
    i2cBitIf.shifter  bus
);

    localparam int BitSelW = $clog2(ByteW);

    logic busy;
    logic active;
    logic [ByteW-1:0] txQ;
    logic [ByteW-1:0] txSrc;
    logic [ByteW-1:0] rxQ;
    logic slaveNackQ;
    logic dataSlot;
    logic [BitSelW-1:0] bitSel;
    logic txBit;

    assign active = busy | bus.stepGo;

    // Bits 0..7 carry data, bit 8 is the acknowledge
    assign dataSlot = (bus.bitIdx < BitIdxW'(ByteW));
    assign bitSel = BitSelW'(ByteW - 1 - int'(bus.bitIdx));

    // txQ is loaded at the end of the stepGo cycle, so bit 7 comes straight from txByte
    assign txSrc = busy ? txQ : bus.txByte;
    assign txBit = txSrc[bitSel];

    always_comb begin
        sdaPullLow = 1'b0;
        if (active) begin
            case (bus.step)
                stepStart, stepRestart: begin
                    // SDA falls halfway through SCL high
                    sdaPullLow = (bus.phase == PhaseSample) || (bus.phase == PhaseFall);
                end
                stepStop: begin
                    sdaPullLow = (bus.phase == PhaseSetup) || (bus.phase == PhaseRise);
                end
                stepWrite: begin
                    // Line is released in the ack slot for the slave
                    sdaPullLow = dataSlot && !txBit;
                end
                stepRead: begin
                    sdaPullLow = !dataSlot && !bus.masterNack;
                end
                default: begin
                    sdaPullLow = 1'b0;
                end
            endcase
        end
    end

    always_ff @(posedge FSM_Clk or negedge rstN) begin
        if (!rstN) begin
            busy <= 1'b0;
        end else if (bus.stepGo) begin
            busy <= 1'b1;
        end else if (bus.stepDone) begin
            busy <= 1'b0;
        end
    end

    // Sample in phase 2 while SCL is high and SDA is settled
    always_ff @(posedge FSM_Clk) begin
        if (bus.stepGo) begin
            txQ <= bus.txByte;
        end
        if (busy && bus.phase == PhaseSample) begin
            if (bus.step == stepRead && dataSlot) begin
                rxQ[bitSel] <= sdaIn;
            end
            if (bus.step == stepWrite && !dataSlot) begin
                slaveNackQ <= sdaIn;
            end
        end
    end

    assign bus.rxByte = rxQ;
    assign bus.slaveNack = slaveNackQ;

endmodule

// File: rtl/i2cBitIf.sv
interface i2cBitIf import i2cPkg::*; ();

    // Step command from the sequencer
    stepE step;
    logic stepGo;
    logic [ByteW-1:0] txByte;
    logic masterNack;

    // Bit timing from the timer
    phaseT phase;
    logic [BitIdxW-1:0] bitIdx;
    logic stepDone;

    // Received data, valid with stepDone
    logic [ByteW-1:0] rxByte;
    logic slaveNack;

    modport seq (
        output step, stepGo, txByte, masterNack,
        input stepDone, rxByte, slaveNack
    );

    modport timer (
        input step, stepGo,
        output phase, bitIdx, stepDone
    );

    modport shifter (
        input step, stepGo, txByte, masterNack, phase, bitIdx, stepDone,
        output rxByte, slaveNack
    );

endinterface

// File: rtl/i2cPkg.sv
package i2cPkg;

    // Bit framing
    localparam int PhasesPerBit = 4;
    localparam int BitsPerByteSlot = 9;
    localparam int BitIdxW = $clog2(BitsPerByteSlot);

    // Data widths
    localparam int ByteW = 8;
    localparam int AddrW = 7;
    localparam int ResultW = 16;

    // Sensor address with A0 and A1 tied low
    localparam logic [AddrW-1:0] DefaultDevAddr = 7'h48;

    // Phase inside one bit time
    typedef logic [1:0] phaseT;

    localparam phaseT PhaseSetup = 2'd0;   // SCL low, SDA may change
    localparam phaseT PhaseRise = 2'd1;    // SCL high
    localparam phaseT PhaseSample = 2'd2;  // SCL high, SDA sampled
    localparam phaseT PhaseFall = 2'd3;    // SCL low again

    // Bit-level opcodes from the sequencer
    typedef enum logic [2:0] {
        stepStart,
        stepRestart,
        stepWrite,
        stepRead,
        stepStop
    } stepE;

    // Transaction states, in bus order
    typedef enum logic [3:0] {
        sIdle,
        sStart,
        sAddrW,
        sPtr,
        sRestart,
        sAddrR,
        sReadMsb,
        sReadLsb,
        sStop,
        sDone
    } seqStateE;

endpackage

// File: rtl/i2cSequencer.sv
module i2cSequencer import i2cPkg::*; #(
    parameter logic [AddrW-1:0] DevAddr = DefaultDevAddr
) (
    input  logic               FSM_Clk,
    input  logic               rstN,
    input  logic               req,
    input  logic [ByteW-1:0]   regPtr,
    output logic               ack,
    output logic [ResultW-1:0] readData,
    output logic               nackSeen,
    i2cBitIf.seq               bus
);

    seqStateE state;
    seqStateE nextState;

    // Result bytes and acknowledge status of the running read
    logic [ResultW-1:0] resultQ;
    logic nackAcc;

    // Step opcode, byte and successor for each state
    always_comb begin
        bus.step = stepWrite;
        bus.txByte = regPtr;
        bus.masterNack = 1'b0;
        nextState = sIdle;
        case (state)
            sStart: begin
                bus.step = stepStart;
                nextState = sAddrW;
            end
            sAddrW: begin
                bus.txByte = {DevAddr, 1'b0};
                nextState = sPtr;
            end
            sPtr: begin
                nextState = sRestart;
            end
            sRestart: begin
                bus.step = stepRestart;
                nextState = sAddrR;
            end
            sAddrR: begin
                bus.txByte = {DevAddr, 1'b1};
                nextState = sReadMsb;
            end
            sReadMsb: begin
                bus.step = stepRead;
                nextState = sReadLsb;
            end
            sReadLsb: begin
                // Last byte is answered with NACK
                bus.step = stepRead;
                bus.masterNack = 1'b1;
                nextState = sStop;
            end
            sStop: begin
                bus.step = stepStop;
                nextState = sDone;
            end
            default: begin
                nextState = sIdle;
            end
        endcase
    end

    always_ff @(posedge FSM_Clk or negedge rstN) begin
        if (!rstN) begin
            state <= sIdle;
            bus.stepGo <= 1'b0;
            ack <= 1'b0;
            readData <= '0;
            nackSeen <= 1'b0;
            nackAcc <= 1'b0;
        end else begin
            bus.stepGo <= 1'b0;
            case (state)
                sIdle: begin
                    if (req) begin
                        state <= sStart;
                        bus.stepGo <= 1'b1;
                        nackAcc <= 1'b0;
                    end
                end
                sStart, sAddrW, sPtr, sRestart, sAddrR, sReadMsb, sReadLsb, sStop: begin
                    if (bus.stepDone) begin
                        // A missing address ACK is only recorded, the read runs on
                        if (bus.step == stepWrite) begin
                            nackAcc <= nackAcc | bus.slaveNack;
                        end
                        state <= nextState;
                        bus.stepGo <= (nextState != sDone);
                    end
                end
                sDone: begin
                    if (!ack) begin
                        ack <= 1'b1;
                        readData <= resultQ;
                        nackSeen <= nackAcc;
                    end else if (!req) begin
                        ack <= 1'b0;
                        state <= sIdle;
                    end
                end
                default: begin
                    state <= sIdle;
                end
            endcase
        end
    end

    // Gather the two read bytes, MSB first
    always_ff @(posedge FSM_Clk) begin
        if (bus.stepDone && state == sReadMsb) begin
            resultQ[ResultW-1:ByteW] <= bus.rxByte;
        end
        if (bus.stepDone && state == sReadLsb) begin
            resultQ[ByteW-1:0] <= bus.rxByte;
        end
    end

endmodule

// File: rtl/tempSensorReader.sv
module tempSensorReader import i2cPkg::*; #(
    parameter logic [AddrW-1:0] DevAddr = DefaultDevAddr,
    parameter logic [15:0] ClkPerPhase = 16'd1
) (
    input  logic               FSM_Clk,
    input  logic               rstN,

    // Host handshake
    input  logic               req,
    input  logic [ByteW-1:0]   regPtr,
    output logic               ack,
    output logic [ResultW-1:0] readData,
    output logic               nackSeen,

    // I2C pins with an open-drain SDA
    output logic               scl,
    output logic               sdaPullLow,
    input  logic               sdaIn
);

    i2cBitIf bitBus ();

    i2cSequencer #(
        .DevAddr (DevAddr)
    ) u_seq (
        .FSM_Clk  (FSM_Clk),
        .rstN     (rstN),
        .req      (req),
        .regPtr   (regPtr),
        .ack      (ack),
        .readData (readData),
        .nackSeen (nackSeen),
        .bus      (bitBus)
    );

    // SCL and bit timing
    bitTimer #(
        .ClkPerPhase (ClkPerPhase)
    ) u_timer (
        .FSM_Clk (FSM_Clk),
        .rstN    (rstN),
        .scl     (scl),
        .bus     (bitBus)
    );

    byteShifter u_shifter (
        .FSM_Clk    (FSM_Clk),
        .rstN       (rstN),
        .sdaIn      (sdaIn),
        .sdaPullLow (sdaPullLow),
        .bus        (bitBus)
    );

endmodule

// File: tempSensorReader.f
rtl/i2cPkg.sv
rtl/i2cBitIf.sv
rtl/i2cSequencer.sv
rtl/bitTimer.sv
rtl/byteShifter.sv
rtl/tempSensorReader.sv
verification/sensorModel.sv
verification/tempSensorReader_chk.sv
verification/tempSensorReader_tb.sv

// File: verification/sensorModel.sv
module sensorModel #(
    parameter logic [6:0] Addr = 7'h48
) (
    input  logic        FSM_Clk,
    input  logic        scl,
    input  logic        sda,
    input  logic        refuseAddr,
    input  logic [15:0] regFile [16],
    output logic        pullLow,
    output logic [7:0]  addrWr,
    output logic [7:0]  addrRd,
    output logic [7:0]  ptrSeen,
    output int          stopCount
);

    typedef enum {mIdle, mAddr, mPtr, mRead, mIgnore} modeE;

    modeE mode = mIdle;
    modeE nextMode = mIgnore;
    logic prevScl = 1'b1;
    logic prevSda = 1'b1;
    logic [7:0] shiftIn = '0;
    logic [7:0] txShift = '0;
    logic masterAck = 1'b0;
    int bitCnt = 0;

    initial begin
        pullLow = 1'b0;
        addrWr = '0;
        addrRd = '0;
        ptrSeen = '0;
        stopCount = 0;
    end

    // Lines are looked at mid-cycle, away from the DUT clock edge
    always @(negedge FSM_Clk) begin
        if (prevScl && scl && prevSda && !sda) begin
            // Start or repeated start
            mode = mAddr;
            bitCnt = 0;
            pullLow = 1'b0;
        end else if (prevScl && scl && !prevSda && sda) begin
            mode = mIdle;
            pullLow = 1'b0;
            stopCount++;
        end else if (!prevScl && scl && mode != mIdle) begin
            if (bitCnt < 8) begin
                shiftIn = {shiftIn[6:0], sda};
            end else if (mode == mRead) begin
                masterAck = !sda;
            end
            bitCnt++;
        end else if (prevScl && !scl && mode != mIdle) begin
            if (bitCnt == 8) begin
                // Answer or release the line after the eighth data bit
                pullLow = 1'b0;
                nextMode = mIgnore;
                if (mode == mAddr) begin
                    if (shiftIn[0]) begin
                        addrRd = shiftIn;
                    end else begin
                        addrWr = shiftIn;
                    end
                    if (shiftIn[7:1] == Addr && !refuseAddr) begin
                        pullLow = 1'b1;
                        nextMode = shiftIn[0] ? mRead : mPtr;
                    end
                end else if (mode == mPtr) begin
                    ptrSeen = shiftIn;
                    pullLow = 1'b1;
                end
            end else if (bitCnt == 9) begin
                bitCnt = 0;
                pullLow = 1'b0;
                if (mode == mRead) begin
                    txShift = regFile[ptrSeen[3:0]][7:0];
                    mode = masterAck ? mRead : mIgnore;
                end else begin
                    txShift = regFile[ptrSeen[3:0]][15:8];
                    mode = nextMode;
                end
            end
            if (mode == mRead && bitCnt < 8) begin
                pullLow = !txShift[7];
                txShift = {txShift[6:0], 1'b0};
            end
        end
        prevScl = scl;
        prevSda = sda;
    end

endmodule

// File: verification/tempSensorReader_chk.sv
module tempSensorReader_chk import i2cPkg::*; (
    input logic               FSM_Clk,
    input logic               rstN,
    input logic               req,
    input logic               ack,
    input logic [ResultW-1:0] readData,
    input logic               scl,
    input logic               sdaIn,
    input seqStateE           seqState
);

    // Host handshake, req must have been high at the edge that raised ack
    ackNeedsReq: assert property (@(posedge FSM_Clk) disable iff (!rstN)
        $rose(ack) |-> $past(req))
        else $error("ack rose while req was low");

    ackHoldsUntilReqFalls: assert property (@(posedge FSM_Clk) disable iff (!rstN)
        (ack && req) |=> ack)
        else $error("ack dropped before req fell");

    dataStableWithAck: assert property (@(posedge FSM_Clk) disable iff (!rstN)
        ack |=> $stable(readData))
        else $error("readData changed while ack was high");

    // SDA may only move under SCL high for start, repeated start and stop
    sdaOnlyForConditions: assert property (@(posedge FSM_Clk) disable iff (!rstN)
        (scl && $past(scl) && !$stable(sdaIn)) |->
            (seqState inside {sStart, sRestart, sStop}))
        else $error("SDA changed during SCL high outside a bus condition");

endmodule

bind tempSensorReader tempSensorReader_chk u_chk (
    .FSM_Clk  (FSM_Clk),
    .rstN     (rstN),
    .req      (req),
    .ack      (ack),
    .readData (readData),
    .scl      (scl),
    .sdaIn    (sdaIn),
    .seqState (u_seq.state)
);

// File: verification/tempSensorReader_tb.sv
module tempSensorReader_tb import i2cPkg::*; ();

    localparam logic [15:0] ClkPerPhase = 16'd2;
    localparam int ReadCycles = 192 * 2 + 2;
    localparam int HoldCycles = 6;
    // Ten transactions plus handshake slack, then room for reset and the hold test
    localparam int CycleLimit = 10 * (192 * 2 + 10) + 300;

    logic FSM_Clk = 1'b0;
    logic rstN;
    logic req;
    logic [ByteW-1:0] regPtr;
    logic ack;
    logic [ResultW-1:0] readData;
    logic nackSeen;
    logic scl;
    logic sdaPullLow;
    logic sdaIn;
    logic modelPullLow;
    logic refuseAddr;
    logic [15:0] regFile [16];
    logic [ByteW-1:0] addrWr;
    logic [ByteW-1:0] addrRd;
    logic [ByteW-1:0] ptrSeen;
    int stopCount;

    logic [31:0] lfsrState = 32'hed3c02a2;
    logic [ResultW-1:0] expData = '0;
    logic expNack = 1'b0;
    logic ackQ = 1'b0;
    int errCount = 0;
    int checkCount = 0;
    int testCount = 0;
    int testFails = 0;
    int cycleCount = 0;

    // Open-drain SDA with pull-up
    assign sdaIn = !(sdaPullLow || modelPullLow);

    always #4 FSM_Clk = ~FSM_Clk;

    tempSensorReader #(
        .ClkPerPhase (ClkPerPhase)
    ) u_dut (
        .FSM_Clk    (FSM_Clk),
        .rstN       (rstN),
        .req        (req),
        .regPtr     (regPtr),
        .ack        (ack),
        .readData   (readData),
        .nackSeen   (nackSeen),
        .scl        (scl),
        .sdaPullLow (sdaPullLow),
        .sdaIn      (sdaIn)
    );

    sensorModel #(
        .Addr (DefaultDevAddr)
    ) u_sensor (
        .FSM_Clk    (FSM_Clk),
        .scl        (scl),
        .sda        (sdaIn),
        .refuseAddr (refuseAddr),
        .regFile    (regFile),
        .pullLow    (modelPullLow),
        .addrWr     (addrWr),
        .addrRd     (addrRd),
        .ptrSeen    (ptrSeen),
        .stopCount  (stopCount)
    );

    // Taps for x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsrNext(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    function automatic logic [31:0] randBits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsrState = lfsrNext(lfsrState);
            v = {v[30:0], lfsrState[0]};
        end
        return v;
    endfunction

    // A refused address leaves SDA to the pull-up, so every read bit is one
    function automatic logic [ResultW-1:0] expectedRead(input logic [ByteW-1:0] ptr,
                                                        input logic refused);
        if (refused) begin
            return '1;
        end else begin
            return regFile[ptr[3:0]];
        end
    endfunction

    task automatic compareVal(input string name, input logic [31:0] exp,
                              input logic [31:0] got);
        checkCount++;
        if (exp !== got) begin
            errCount++;
            $display("mismatch %s exp %h got %h", name, exp, got);
        end
    endtask

    task automatic finishTest(input string name, input int errBefore);
        testCount++;
        if (errCount == errBefore) begin
            $display("test %s passed", name);
        end else begin
            testFails++;
            $display("test %s failed with %0d errors", name, errCount - errBefore);
        end
    endtask

    // One full handshake, optionally holding req after ack
    task automatic doRead(input logic [ByteW-1:0] ptr, input int holdCycles);
        int latency;
        logic [ResultW-1:0] heldData;
        expData = expectedRead(ptr, refuseAddr);
        expNack = refuseAddr;
        regPtr = ptr;
        req = 1'b1;
        latency = 0;
        while (!ack) begin
            @(negedge FSM_Clk);
            latency++;
        end
        compareVal("ackLatency", ReadCycles, latency);
        heldData = readData;
        repeat (holdCycles) begin
            @(negedge FSM_Clk);
            compareVal("ack", 32'(1'b1), 32'(ack));
            compareVal("readData", 32'(heldData), 32'(readData));
        end
        req = 1'b0;
        @(negedge FSM_Clk);
        compareVal("ack", 32'(1'b0), 32'(ack));
    endtask

    // Result check on each rising ack
    always @(negedge FSM_Clk) begin
        if (ack && !ackQ) begin
            compareVal("readData", 32'(expData), 32'(readData));
            compareVal("nackSeen", 32'(expNack), 32'(nackSeen));
        end
        ackQ <= ack;
    end

    always @(posedge FSM_Clk) begin
        cycleCount++;
        if (cycleCount > CycleLimit) begin
            $display("timeout after %0d cycles, a handshake did not complete", cycleCount);
            $display("Test FAILED");
            $finish;
        end
    end

    initial begin
        logic [ByteW-1:0] ptr;
        int errBefore;
        int stopsBefore;
        rstN = 1'b0;
        req = 1'b0;
        regPtr = '0;
        refuseAddr = 1'b0;
        for (int i = 0; i < 16; i++) begin
            regFile[i[3:0]] = 16'(randBits(16));
        end
        repeat (2) @(negedge FSM_Clk);
        rstN = 1'b1;

        errBefore = errCount;
        compareVal("ack", 32'(1'b0), 32'(ack));
        compareVal("scl", 32'(1'b1), 32'(scl));
        compareVal("sdaPullLow", 32'(1'b0), 32'(sdaPullLow));
        compareVal("readData", 32'(16'h0000), 32'(readData));
        compareVal("nackSeen", 32'(1'b0), 32'(nackSeen));
        finishTest("reset values", errBefore);

        errBefore = errCount;
        doRead(8'h00, 0);
        finishTest("read pointer 0", errBefore);

        errBefore = errCount;
        repeat (6) begin
            ptr = 8'(randBits(4));
            doRead(ptr, 0);
            compareVal("addrWr", 32'({DefaultDevAddr, 1'b0}), 32'(addrWr));
            compareVal("ptrSeen", 32'(ptr), 32'(ptrSeen));
            compareVal("addrRd", 32'({DefaultDevAddr, 1'b1}), 32'(addrRd));
        end
        finishTest("random pointer reads", errBefore);

        errBefore = errCount;
        refuseAddr = 1'b1;
        stopsBefore = stopCount;
        doRead(8'h03, 0);
        compareVal("stopCount", 32'(stopsBefore + 1), 32'(stopCount));
        refuseAddr = 1'b0;
        doRead(8'h05, 0);
        finishTest("address nack", errBefore);

        errBefore = errCount;
        doRead(8'(randBits(4)), HoldCycles);
        finishTest("req hold", errBefore);

        $display("tests %0d, failed %0d, checks %0d, errors %0d",
                 testCount, testFails, checkCount, errCount);
        if (errCount == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule
